/* files.f */
+incdir+.
lease_types_pkg.sv
lease_bus_pkg.sv
lease_lookup_table.sv
lease_lfsr.sv
lease_register_file.sv
lease_controller.sv
lease_policy_top.sv
tb_lease_policy.sv

/* Bender.yml */
package:
  name: lease_policy

export_include_dirs:
  - .

sources:
  - lease_types_pkg.sv
  - lease_bus_pkg.sv
  - lease_lookup_table.sv
  - lease_lfsr.sv
  - lease_register_file.sv
  - lease_controller.sv
  - lease_policy_top.sv
  - target: test
    files:
      - tb_lease_policy.sv

/* tb_lease_policy.sv */
`timescale 1ns/1ps
`include "lease_defs.svh"

module tb_lease_policy
	import lease_types_pkg::*;
	import lease_bus_pkg::*;
();
	localparam int N_ENT = `LLT_N_ENTRIES;
	localparam int N_LINES = `LEASE_N_LINES;
	localparam int DONE_TIMEOUT = 10;	// cycles allowed until done_o

	logic			clock, resetn, req_valid, done, hit;
	llt_prog_t		prog;
	lease_req_t		req;
	lease_t			lease;
	logic [N_LINES-1:0]	expired;
	int			err_cnt;
	int unsigned		seed;

	// ----------------------------------------
	// reference model state
	// ----------------------------------------
	bit		m_valid [N_ENT];
	ref_addr_t	m_ref [N_ENT];
	lease_t		m_l0 [N_ENT], m_l1 [N_ENT];
	prob_t		m_prob [N_ENT];
	prob_t		m_lfsr;			// dut lfsr copy
	lease_t		m_line [N_LINES];	// per line countdown

	lease_policy_top u_lease_policy_top (.clock_i(clock), .resetn_i(resetn), .prog_i(prog),
		.req_valid_i(req_valid), .req_i(req), .done_o(done), .hit_o(hit),
		.lease_o(lease), .expired_o(expired));

	always #10 clock = ~clock;	// 20 ns period

	task automatic check_lease(lease_t got, lease_t exp, string what);
		if (got !== exp) begin
			$display("ERR %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_hit(logic got, bit exp, string what);
		if (got !== exp) begin
			$display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_expired(logic [N_LINES-1:0] got, logic [N_LINES-1:0] exp, string what);
		if (got !== exp) begin
			$display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	// one write or remove strobe, model takes the same update
	task automatic prog_op(logic [1:0] arr, int idx, logic [31:0] data, bit rm);
		@(negedge clock);
		prog.addr = table_addr_t'((int'(arr) << `CLOG2(`LLT_N_ENTRIES)) | idx);
		prog.data = data;
		prog.wren = !rm;
		prog.rmen = rm;
		case (arr)
			2'b00: begin
				m_valid[idx] = !rm;
				if (!rm)
					m_ref[idx] = data[`BW_REF_ADDR+1:2];	// byte to word address
			end
			2'b01: m_l0[idx] = data[`BW_LEASE-1:0];
			2'b10: m_l1[idx] = data[`BW_LEASE-1:0];
			default: m_prob[idx] = data[`BW_PERCENTAGE-1:0];
		endcase
		@(negedge clock);
		prog.wren = 1'b0;
		prog.rmen = 1'b0;
	endtask

	// request, then compare hit, lease and the countdown against the model
	task automatic do_request(word_addr_t addr, line_idx_t ln, bit hold);
		bit			e_hit = 1'b0;
		lease_t			e_lease = lease_t'(`LEASE_DEFAULT);	// miss value
		logic [N_LINES-1:0]	e_exp;
		int			wait_cnt;
		for (int i = 0; i < N_ENT; i++) begin	// later match overrides
			if (m_valid[i] && m_ref[i] == addr[`BW_REF_ADDR-1:0]) begin
				e_hit = 1'b1;
				e_lease = (m_lfsr < m_prob[i]) ? m_l0[i] : m_l1[i];
			end
		end
		@(negedge clock);
		req_valid = 1'b1;
		req.word_addr = addr;
		req.line = ln;
		@(negedge clock);
		for (wait_cnt = 1; !done && wait_cnt < DONE_TIMEOUT; wait_cnt++)
			@(negedge clock);
		req_valid = hold;	// held high means into the assign cycle
		if (!done) begin
			$display("no done_o within %0d cycles for address %h", DONE_TIMEOUT, addr);
			err_cnt++;
			req_valid = 1'b0;
			return;
		end
		check_hit(hit, e_hit, "hit_o");
		check_lease(lease, e_lease, "lease_o");
		for (int i = 0; i < N_LINES; i++) begin
			if (line_idx_t'(i) == ln)
				m_line[i] = e_lease;	// target line reloads
			else if (m_line[i] != '0)
				m_line[i]--;
			e_exp[i] = (m_line[i] == '0);
		end
		m_lfsr = {m_lfsr[7:0], m_lfsr[8] ^ m_lfsr[4]};	// x^9 + x^5 + 1
		@(negedge clock);
		req_valid = 1'b0;
		check_hit(done, 1'b0, "done_o after assign");	// a second done means a second accept
		check_expired(expired, e_exp, "expired_o");
	endtask

	initial begin
		logic [31:0]	d;
		int		k;
		{clock, resetn, req_valid} = '0;
		prog = '0;
		req = '0;
		err_cnt = 0;
		seed = $urandom(32'hba467efd);
		m_lfsr = 9'h001;
		m_valid = '{default: 1'b0};
		m_line = '{default: '0};
		repeat (5) @(posedge clock);
		@(negedge clock);
		resetn = 1'b1;

		// ----------------------------------------
		// empty table after reset
		@(negedge clock);
		check_expired(expired, '1, "expired_o after reset");
		repeat (3) do_request(word_addr_t'($urandom), line_idx_t'($urandom), 1'b0);

		// all arrays, prob 0 and 511 on every fourth entry
		for (int i = 0; i < N_ENT; i++) begin
			prog_op(2'b00, i, $urandom, 1'b0);
			prog_op(2'b01, i, $urandom_range(0, 12), 1'b0);	// short, lines do expire
			prog_op(2'b10, i, $urandom_range(0, 12), 1'b0);
			prog_op(2'b11, i, (i % 4 == 0) ? 0 : (i % 4 == 1) ? 511 : $urandom, 1'b0);
		end
		for (int n = 0; n < 40; n++) begin
			k = $urandom_range(0, N_ENT - 1);
			do_request(word_addr_t'({$urandom, m_ref[k]}), line_idx_t'($urandom), 1'b0);
		end

		// removed entries miss from now on
		for (int n = 0; n < 4; n++) begin
			k = $urandom_range(0, N_ENT - 1);
			prog_op(2'b00, k, '0, 1'b1);
			do_request(word_addr_t'({$urandom, m_ref[k]}), line_idx_t'($urandom), 1'b0);
		end

		// same address in entries 5 and 14, distinct leases
		d = $urandom;
		prog_op(2'b00, 5, d, 1'b0);
		prog_op(2'b00, 14, d, 1'b0);
		prog_op(2'b01, 5, 32'd3, 1'b0);
		prog_op(2'b10, 5, 32'd3, 1'b0);
		prog_op(2'b01, 14, 32'd7, 1'b0);
		prog_op(2'b10, 14, 32'd7, 1'b0);
		repeat (3) do_request(word_addr_t'({$urandom, m_ref[5]}), line_idx_t'($urandom), 1'b0);

		repeat (20) do_request(word_addr_t'($urandom), line_idx_t'($urandom), 1'b0);
		do_request(word_addr_t'({$urandom, m_ref[14]}), line_idx_t'($urandom), 1'b1);

		$display("error count: %0d", err_cnt);
		if (err_cnt == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* lease_policy_top.sv */
`timescale 1ns/1ps
`include "lease_defs.svh"

module lease_policy_top
	import lease_types_pkg::*;
	import lease_bus_pkg::*;
(
	input  logic		clock_i,
	input  logic		resetn_i,

	input  llt_prog_t	prog_i,		// host programming
	input  logic		req_valid_i,
	input  lease_req_t	req_i,

	output logic		done_o,
	output logic		hit_o,
	output lease_t		lease_o,
	output logic [`LEASE_N_LINES-1:0]	expired_o
);

	word_addr_t	search_addr;
	lease_result_t	result;
	prob_t		rand_val;
	logic		load, step;
	line_idx_t	line;

	// ----------------------------------------
	// control
	// ----------------------------------------
	lease_controller u_lease_controller (
		.clock_i	(clock_i),
		.resetn_i	(resetn_i),
		.req_valid_i	(req_valid_i),
		.req_i		(req_i),
		.search_addr_o	(search_addr),
		.result_i	(result),
		.rand_i		(rand_val),
		.load_o		(load),
		.line_o		(line),
		.lease_o	(lease_o),	// also feeds the register file
		.step_o		(step),
		.done_o		(done_o),
		.hit_o		(hit_o)
	);

	// ----------------------------------------
	// datapath
	// ----------------------------------------
	lease_lookup_table u_lease_lookup_table (
		.clock_i	(clock_i),
		.resetn_i	(resetn_i),
		.prog_i		(prog_i),
		.search_addr_i	(search_addr),
		.result_o	(result)
	);

	lease_lfsr u_lease_lfsr (
		.clock_i	(clock_i),
		.resetn_i	(resetn_i),
		.step_i		(step),
		.value_o	(rand_val)
	);

	lease_register_file u_lease_register_file (
		.clock_i	(clock_i),
		.resetn_i	(resetn_i),
		.load_i		(load),
		.line_i		(line),
		.lease_i	(lease_o),
		.expired_o	(expired_o)
	);

endmodule

/* lease_controller.sv */
`timescale 1ns/1ps
`include "lease_defs.svh"

module lease_controller
	import lease_types_pkg::*;
	import lease_bus_pkg::*;
(
	input  logic		clock_i,
	input  logic		resetn_i,

	// cache side
	input  logic		req_valid_i,
	input  lease_req_t	req_i,

	// table search
	output word_addr_t	search_addr_o,
	input  lease_result_t	result_i,

	input  prob_t		rand_i,		// current lfsr value

	// datapath strobes
	output logic		load_o,
	output line_idx_t	line_o,
	output lease_t		lease_o,
	output logic		step_o,

	output logic		done_o,
	output logic		hit_o
);

	// ----------------------------------------
	// fsm
	// ----------------------------------------
	lease_state_t	state_q, state_d;
	lease_req_t	req_q;		// request held for the assign cycle
	logic		assign_c;

	always_comb begin
		state_d = state_q;
		case (state_q)
			LS_IDLE:   if (req_valid_i) state_d = LS_ASSIGN;
			LS_ASSIGN: state_d = LS_IDLE;	// always one cycle
			default:   state_d = LS_IDLE;
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			state_q <= LS_IDLE;
		else
			state_q <= state_d;
	end

	// capture only when idle, a request during assign is dropped
	always_ff @(posedge clock_i) begin
		if (state_q == LS_IDLE && req_valid_i)
			req_q <= req_i;
	end

	assign assign_c = (state_q == LS_ASSIGN);

	// ----------------------------------------
	// lease selection
	// ----------------------------------------
	assign search_addr_o = req_q.word_addr;
	assign line_o        = req_q.line;
	assign hit_o         = result_i.hit;

	always_comb begin
		if (!result_i.hit)
			lease_o = lease_t'(`LEASE_DEFAULT);
		else if (rand_i < result_i.prob)	// strictly below picks lease0
			lease_o = result_i.lease0;
		else
			lease_o = result_i.lease1;
	end

	// same pulse for all three
	assign load_o = assign_c;
	assign step_o = assign_c;
	assign done_o = assign_c;

	a_done_single: assert property (@(posedge clock_i) disable iff (!resetn_i)
		done_o |=> !done_o)
		else $error("done held high for two cycles");

endmodule

/* lease_register_file.sv */
`timescale 1ns/1ps
`include "lease_defs.svh"

module lease_register_file
	import lease_types_pkg::*;
(
	input  logic	clock_i,
	input  logic	resetn_i,

	input  logic		load_i,		// one pulse per request
	input  line_idx_t	line_i,		// line to reload
	input  lease_t		lease_i,	// new lease for that line

	output logic [`LEASE_N_LINES-1:0]	expired_o	// line lease has run out
);

	// ----------------------------------------
	// per line lease counters
	// ----------------------------------------
	lease_t lease_q [`LEASE_N_LINES];

	// target line reloads, all others count down towards zero
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int i = 0; i < `LEASE_N_LINES; i++)
				lease_q[i] <= '0;	// everything starts expired
		end else if (load_i) begin
			for (int i = 0; i < `LEASE_N_LINES; i++) begin
				if (line_idx_t'(i) == line_i)
					lease_q[i] <= lease_i;
				else if (lease_q[i] != '0)
					lease_q[i] <= lease_q[i] - 1'b1;	// saturate at zero
			end
		end
	end

	// expired flags
	always_comb begin
		for (int i = 0; i < `LEASE_N_LINES; i++)
			expired_o[i] = (lease_q[i] == '0);
	end

endmodule

/* lease_lfsr.sv */
`timescale 1ns/1ps

module lease_lfsr
	import lease_types_pkg::*;
(
	input  logic	clock_i,
	input  logic	resetn_i,
	input  logic	step_i,		// one step per accepted request
	output prob_t	value_o
);

	prob_t lfsr_q;

	// x^9 + x^5 + 1, maximal length, 511 states
	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			lfsr_q <= 9'h001;	// any nonzero seed
		else if (step_i)
			lfsr_q <= {lfsr_q[7:0], lfsr_q[8] ^ lfsr_q[4]};
	end

	assign value_o = lfsr_q;

	// all-zero is the lock-up state
	a_lfsr_nonzero: assert property (@(posedge clock_i) disable iff (!resetn_i)
		lfsr_q != '0)
		else $error("lfsr stuck at zero");

endmodule

/* lease_lookup_table.sv */
`timescale 1ns/1ps
`include "lease_defs.svh"

module lease_lookup_table
	import lease_types_pkg::*;
	import lease_bus_pkg::*;
(
	input  logic		clock_i,
	input  logic		resetn_i,

	input  llt_prog_t	prog_i,		// host write / remove port
	input  word_addr_t	search_addr_i,	// word address of the request
	output lease_result_t	result_o	// combinational search result
);

	localparam int BW_ENTRY = `CLOG2(`LLT_N_ENTRIES);
	localparam int BW_TADDR = $bits(table_addr_t);

	// ----------------------------------------
	// storage
	// ----------------------------------------
	logic [`LLT_N_ENTRIES-1:0]	valid_q;	// set by ref addr write
	ref_addr_t	ref_addr_mem [`LLT_N_ENTRIES];
	lease_t		lease0_mem [`LLT_N_ENTRIES];
	lease_t		lease1_mem [`LLT_N_ENTRIES];
	prob_t		prob_mem [`LLT_N_ENTRIES];

	logic [1:0]		arr_sel;	// 00 ref, 01 lease0, 10 lease1, 11 prob
	logic [BW_ENTRY-1:0]	entry_idx;

	assign arr_sel   = prog_i.addr[BW_TADDR-1 -: 2];
	assign entry_idx = prog_i.addr[BW_ENTRY-1:0];

	// valid bits, only array 00 touches them
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
		end else if (arr_sel == 2'b00) begin
			if (prog_i.wren)
				valid_q[entry_idx] <= 1'b1;
			else if (prog_i.rmen)
				valid_q[entry_idx] <= 1'b0;	// eviction
		end
	end

	// payload arrays
	always_ff @(posedge clock_i) begin
		if (prog_i.wren) begin
			case (arr_sel)
				2'b00: ref_addr_mem[entry_idx] <= prog_i.data[`BW_REF_ADDR+1:2]; // byte -> word
				2'b01: lease0_mem[entry_idx]   <= prog_i.data[`BW_LEASE-1:0];
				2'b10: lease1_mem[entry_idx]   <= prog_i.data[`BW_LEASE-1:0];
				default: prob_mem[entry_idx]   <= prog_i.data[`BW_PERCENTAGE-1:0];
			endcase
		end
	end

	// ----------------------------------------
	// search
	// ----------------------------------------
	logic [`LLT_N_ENTRIES-1:0] hit_vec;

	// one comparator per entry
	always_comb begin
		for (int i = 0; i < `LLT_N_ENTRIES; i++)
			hit_vec[i] = valid_q[i] && (ref_addr_mem[i] == search_addr_i[`BW_REF_ADDR-1:0]);
	end

	// priority mux, later entries override so highest index wins
	always_comb begin
		result_o = '0;
		result_o.hit = |hit_vec;
		for (int i = 0; i < `LLT_N_ENTRIES; i++) begin
			if (hit_vec[i]) begin
				result_o.lease0 = lease0_mem[i];
				result_o.lease1 = lease1_mem[i];
				result_o.prob   = prob_mem[i];
			end
		end
	end

	// host must not write and remove in the same cycle
	a_wren_rmen_excl: assert property (@(posedge clock_i) disable iff (!resetn_i)
		!(prog_i.wren && prog_i.rmen))
		else $error("lease table: wren and rmen high together");

endmodule

/* lease_bus_pkg.sv */
package lease_bus_pkg;

	import lease_types_pkg::*;

	// host programming strobes
	typedef struct packed {
		table_addr_t	addr;
		logic		wren;	// write data into addr
		logic		rmen;	// invalidate entry, ref addr array only
		logic [31:0]	data;
	} llt_prog_t;

	// cache request
	typedef struct packed {
		word_addr_t	word_addr;
		line_idx_t	line;	// line that receives the lease
	} lease_req_t;

	// table search result
	typedef struct packed {
		logic		hit;
		lease_t		lease0;
		lease_t		lease1;
		prob_t		prob;	// probability of lease0
	} lease_result_t;

	typedef enum logic {LS_IDLE, LS_ASSIGN} lease_state_t;

endpackage

/* lease_types_pkg.sv */
`include "lease_defs.svh"

package lease_types_pkg;

	// ----------------------------------------
	// vector types with a meaning
	// ----------------------------------------
	typedef logic [`BW_WORD_ADDR-1:0]	word_addr_t;	// request word address
	typedef logic [`BW_REF_ADDR-1:0]	ref_addr_t;	// tag stored per entry
	typedef logic [`BW_LEASE-1:0]		lease_t;
	typedef logic [`BW_PERCENTAGE-1:0]	prob_t;		// chance of lease0, out of 512

	typedef logic [`CLOG2(`LEASE_N_LINES)-1:0] line_idx_t;	// cache line index

	// programming address
	// top two bits select the array, rest select the entry
	typedef logic [`CLOG2(`LLT_N_ENTRIES)+1:0] table_addr_t;

endpackage

/* lease_defs.svh */
`ifndef LEASE_DEFS_SVH
`define LEASE_DEFS_SVH

// ----------------------------------------
// sizing of table and lease registers
// ----------------------------------------
`define LLT_N_ENTRIES	16	// lookup table entries
`define LEASE_N_LINES	16	// cache lines, one lease register each

// field widths
`define BW_WORD_ADDR	30	// byte address minus the two low bits
`define BW_REF_ADDR	20	// stored part of a reference address
`define BW_LEASE	16
`define BW_PERCENTAGE	9	// matches the lfsr width

`define LEASE_DEFAULT	1	// lease given on a table miss

`define CLOG2(x) $clog2(x)

`endif
